/* hdl/load_pkg.sv */
package load_pkg;

    // --------------------
    // widths
    // --------------------

    // virtual and physical address widths of the core
    localparam int unsigned VADDR_W    = 32;
    localparam int unsigned PADDR_W    = 34;
    // the cache index doubles as the page offset of a 4 KiB page
    localparam int unsigned INDEX_W    = 12;
    // tag is whatever is left of the physical address above the index
    localparam int unsigned TAG_W      = PADDR_W - INDEX_W;
    localparam int unsigned DATA_W     = 64;
    localparam int unsigned TRANS_ID_W = 3;

    // --------------------
    // vector types
    // --------------------

    typedef logic [VADDR_W-1:0]    vaddr_t;
    typedef logic [PADDR_W-1:0]    paddr_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [TRANS_ID_W-1:0] trans_id_t;
    // byte position inside the 64-bit data word
    typedef logic [2:0]            byte_off_t;
    typedef logic [7:0]            be_t;
    // transfer size encodes the byte count as its log2
    typedef logic [1:0]            size_t;

    // load operations handled by the unit
    typedef enum logic [2:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } load_op_t;

    // --------------------
    // structs
    // --------------------

    // one load request as it arrives from issue
    typedef struct packed {
        vaddr_t    vaddr;
        be_t       be;
        load_op_t  op;
        trans_id_t trans_id;
    } load_ctrl_t;

    // read-only request port towards the data cache
    typedef struct packed {
        index_t address_index;
        tag_t   address_tag;
        logic   data_req;
        be_t    data_be;
        size_t  data_size;
        logic   kill_req;
        logic   tag_valid;
    } dcache_req_t;

    // answer from the data cache
    typedef struct packed {
        logic  data_gnt;
        logic  data_rvalid;
        data_t data_rdata;
    } dcache_rsp_t;

    // what has to survive until the read data comes back
    typedef struct packed {
        trans_id_t trans_id;
        byte_off_t offset;
        load_op_t  op;
    } load_info_t;

    // map a load operation onto the size field of the cache request
    function automatic size_t load_size(load_op_t op);
        case (op)
            LD:       return 2'd3;
            LW, LWU:  return 2'd2;
            LH, LHU:  return 2'd1;
            default:  return 2'd0;
        endcase
    endfunction

endpackage

/* hdl/load_req_ctrl.sv */
`timescale 1ns/1ns

module load_req_ctrl (
    input  logic clk_i,
    input  logic rst_ni,
    // request side
    input  logic valid_i,
    input  logic flush_i,
    input  logic ex_valid_i,
    // store checker says a pending store hits the same page offset
    input  logic page_offset_match_i,
    // translation result, same cycle as the request
    input  logic dtlb_hit_i,
    // cache handshake
    input  logic data_gnt_i,
    input  logic data_rvalid_i,
    output logic translation_req_o,
    output logic data_req_o,
    output logic kill_req_o,
    output logic tag_valid_o,
    // request consumed, the issue side may move on
    output logic pop_ld_o,
    // capture the request into the load information register
    output logic load_o,
    // an rvalid in this cycle may retire
    output logic rsp_ok_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e state_d, state_q;

    // the cache request is up in this cycle and the grant decides where to go
    logic issue;

    // --------------------
    // request sequencing
    // --------------------

    always_comb begin
        state_d           = state_q;
        issue             = 1'b0;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        kill_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        pop_ld_o          = 1'b0;

        case (state_q)
            IDLE: begin
                if (valid_i) begin
                    // translation starts right away, before the offset check has settled
                    translation_req_o = 1'b1;
                    // a request with an exception never reaches the cache
                    if (!ex_valid_i) begin
                        if (page_offset_match_i) begin
                            state_d = WAIT_PAGE_OFFSET;
                        end else begin
                            issue = 1'b1;
                        end
                    end
                end
            end

            // hold off the cache until the colliding store has drained
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_match_i) begin
                    state_d = WAIT_GNT;
                end
            end

            WAIT_GNT: begin
                // request and translation stay up until the grant arrives
                translation_req_o = 1'b1;
                issue             = 1'b1;
            end

            SEND_TAG: begin
                // the translated tag of the granted request goes out now
                tag_valid_o = 1'b1;
                state_d     = IDLE;
                // a new request can start in the same cycle as the tag
                if (valid_i) begin
                    translation_req_o = 1'b1;
                    if (!ex_valid_i) begin
                        if (page_offset_match_i) begin
                            state_d = WAIT_PAGE_OFFSET;
                        end else begin
                            issue = 1'b1;
                        end
                    end
                end
            end

            // TLB missed after the grant so the cache slot has to be released
            ABORT_TRANSACTION: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end

            WAIT_TRANSLATION: begin
                // keep asking the MMU, the page walk runs meanwhile
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            WAIT_FLUSH: begin
                // kill whatever might still be open in the cache
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // grant handling shared by the accept path and the grant wait
        if (issue) begin
            data_req_o = 1'b1;
            if (!data_gnt_i) begin
                state_d = WAIT_GNT;
            end else if (dtlb_hit_i) begin
                // grant and hit together, the tag follows in the next cycle
                state_d  = SEND_TAG;
                pop_ld_o = 1'b1;
            end else begin
                state_d = ABORT_TRANSACTION;
            end
        end

        // an excepting request retires right away without touching the cache
        if (valid_i && ex_valid_i) begin
            state_d = IDLE;
            // an rvalid takes the response port first, the exception goes next cycle
            if (!data_rvalid_i) begin
                pop_ld_o = 1'b1;
            end
        end

        // flush wins over everything else
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // only a real load needs its information stored for the response
    assign load_o = pop_ld_o & ~ex_valid_i;

    // data is dropped while flushing, while waiting for translation and when killed
    assign rsp_ok_o = data_rvalid_i
                    & (state_q != WAIT_FLUSH)
                    & (state_q != WAIT_TRANSLATION)
                    & (~kill_req_o | ex_valid_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* hdl/load_info_reg.sv */
`timescale 1ns/1ns

module load_info_reg (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // capture strobe from the request controller
    input  logic                  load_i,
    input  load_pkg::load_info_t  info_i,
    output load_pkg::load_info_t  info_o,
    // byte whose top bit is the sign of the loaded value
    output load_pkg::byte_off_t   sign_idx_o,
    output logic                  signed_o
);

    import load_pkg::*;

    load_info_t info_q;
    byte_off_t  sign_idx_d, sign_idx_q;
    logic       signed_d, signed_q;

    // --------------------
    // sign precompute
    // --------------------

    // the sign sits in the highest byte of the value, counted from the offset
    always_comb begin
        case (info_i.op)
            LW:      sign_idx_d = byte_off_t'(info_i.offset + 3'd3);
            LH:      sign_idx_d = byte_off_t'(info_i.offset + 3'd1);
            default: sign_idx_d = info_i.offset;
        endcase
    end

    // unsigned ops and LD never extend, so their sign is forced low later
    assign signed_d = (info_i.op inside {LW, LH, LB});

    // one entry only, since a single load is outstanding at any time
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            info_q     <= '0;
            sign_idx_q <= '0;
            signed_q   <= 1'b0;
        end else if (load_i) begin
            info_q     <= info_i;
            sign_idx_q <= sign_idx_d;
            signed_q   <= signed_d;
        end
    end

    assign info_o     = info_q;
    assign sign_idx_o = sign_idx_q;
    assign signed_o   = signed_q;

endmodule

/* hdl/load_result_align.sv */
`timescale 1ns/1ns

module load_result_align (
    // raw 64-bit word from the cache
    input  load_pkg::data_t       rdata_i,
    // stored entry of the outstanding load
    input  load_pkg::load_info_t  info_i,
    input  load_pkg::byte_off_t   sign_idx_i,
    input  logic                  signed_i,
    output load_pkg::data_t       result_o
);

    import load_pkg::*;

    data_t     shifted;
    logic [7:0] sign_bits;
    logic      sign_bit;

    // --------------------
    // realign
    // --------------------

    // bring the addressed byte down to bit 0
    assign shifted = rdata_i >> {info_i.offset, 3'b000};

    // top bit of every byte, picked in parallel with the shifter
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            sign_bits[i] = rdata_i[8*i+7];
        end
    end

    // unsigned loads pull the sign low
    assign sign_bit = signed_i & sign_bits[sign_idx_i];

    // --------------------
    // extension
    // --------------------

    always_comb begin
        case (info_i.op)
            LW, LWU: result_o = {{32{sign_bit}}, shifted[31:0]};
            LH, LHU: result_o = {{48{sign_bit}}, shifted[15:0]};
            LB, LBU: result_o = {{56{sign_bit}}, shifted[7:0]};
            // full doubleword, nothing to extend
            default: result_o = shifted;
        endcase
    end

endmodule

/* hdl/load_unit.sv */
`timescale 1ns/1ns

module load_unit (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    // issue side
    input  logic                   valid_i,
    input  load_pkg::load_ctrl_t   lsu_ctrl_i,
    input  logic                   ex_valid_i,
    output logic                   pop_ld_o,
    // writeback side
    output logic                   valid_o,
    output load_pkg::trans_id_t    trans_id_o,
    output load_pkg::data_t        result_o,
    // MMU
    output logic                   translation_req_o,
    output load_pkg::vaddr_t       vaddr_o,
    input  load_pkg::paddr_t       paddr_i,
    input  logic                   dtlb_hit_i,
    // store checker
    input  logic                   page_offset_match_i,
    // data cache
    output load_pkg::dcache_req_t  dcache_req_o,
    input  load_pkg::dcache_rsp_t  dcache_rsp_i
);

    import load_pkg::*;

    logic       load;
    logic       rsp_ok;
    load_info_t info_in;
    load_info_t info_q;
    byte_off_t  sign_idx;
    logic       sign_en;

    // the MMU and the store checker both look at the raw virtual address
    assign vaddr_o = lsu_ctrl_i.vaddr;

    // --------------------
    // cache request
    // --------------------

    // index goes out with the request, the tag one cycle after the grant
    assign dcache_req_o.address_index = lsu_ctrl_i.vaddr[INDEX_W-1:0];
    assign dcache_req_o.address_tag   = paddr_i[PADDR_W-1:INDEX_W];
    assign dcache_req_o.data_be       = lsu_ctrl_i.be;
    assign dcache_req_o.data_size     = load_size(lsu_ctrl_i.op);

    load_req_ctrl i_load_req_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .valid_i             (valid_i),
        .flush_i             (flush_i),
        .ex_valid_i          (ex_valid_i),
        .page_offset_match_i (page_offset_match_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .data_gnt_i          (dcache_rsp_i.data_gnt),
        .data_rvalid_i       (dcache_rsp_i.data_rvalid),
        .translation_req_o   (translation_req_o),
        .data_req_o          (dcache_req_o.data_req),
        .kill_req_o          (dcache_req_o.kill_req),
        .tag_valid_o         (dcache_req_o.tag_valid),
        .pop_ld_o            (pop_ld_o),
        .load_o              (load),
        .rsp_ok_o            (rsp_ok)
    );

    // --------------------
    // response
    // --------------------

    // low three address bits give the byte offset inside the data word
    assign info_in = '{trans_id: lsu_ctrl_i.trans_id,
                       offset:   lsu_ctrl_i.vaddr[2:0],
                       op:       lsu_ctrl_i.op};

    load_info_reg i_load_info_reg (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .load_i     (load),
        .info_i     (info_in),
        .info_o     (info_q),
        .sign_idx_o (sign_idx),
        .signed_o   (sign_en)
    );

    load_result_align i_load_result_align (
        .rdata_i    (dcache_rsp_i.data_rdata),
        .info_i     (info_q),
        .sign_idx_i (sign_idx),
        .signed_i   (sign_en),
        .result_o   (result_o)
    );

    // an exception retires at once unless read data needs the port this cycle
    always_comb begin
        valid_o    = rsp_ok;
        trans_id_o = info_q.trans_id;
        if (valid_i && ex_valid_i && !dcache_rsp_i.data_rvalid) begin
            valid_o    = 1'b1;
            trans_id_o = lsu_ctrl_i.trans_id;
        end
    end

endmodule

/* include/load_tb_tasks.svh */
// --------------------
// cycle helpers
// --------------------

// inputs change right at the falling edge
task automatic next_cycle();
    @(negedge clk_i);
endtask

// let combinational outputs follow the new inputs before sampling
task automatic settle();
    #1;
endtask

task automatic check_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else report_mismatch(sig, got, exp);
endtask

// one cycle of a bounded wait
// the caller clears wait_cnt before the first call
task automatic count_wait(input string what);
    @(negedge clk_i);
    #1;
    wait_cnt++;
    if (wait_cnt > wait_limit) begin
        report_timeout(what);
    end
endtask

function automatic data_t random_word();
    return {$random(seed), $random(seed)};
endfunction

// shift the addressed byte to bit 0 and keep the op's width
// then extend with the top bit of that slice for the signed ops
function automatic data_t expected_result(load_op_t op, byte_off_t off, data_t rdata);
    data_t word;
    word = rdata >> (8 * off);
    case (op)
        LW:      return {{32{word[31]}}, word[31:0]};
        LWU:     return {32'b0, word[31:0]};
        LH:      return {{48{word[15]}}, word[15:0]};
        LHU:     return {48'b0, word[15:0]};
        LB:      return {{56{word[7]}}, word[7:0]};
        LBU:     return {56'b0, word[7:0]};
        default: return word;
    endcase
endfunction

// transfer size is the log2 of the number of bytes the op reads
function automatic size_t expected_size(load_op_t op);
    int    bytes;
    size_t size;
    case (op)
        LD:      bytes = 8;
        LW, LWU: bytes = 4;
        LH, LHU: bytes = 2;
        default: bytes = 1;
    endcase
    size = 2'd0;
    while ((1 << size) < bytes) begin
        size++;
    end
    return size;
endfunction

// the core issues naturally aligned addresses with matching byte enables
task automatic drive_request(input load_op_t op, input trans_id_t id);
    vaddr_t va;
    be_t    mask;
    va = $random(seed);
    case (op)
        LD: begin
            va[2:0] = 3'b000;
            mask    = 8'hff;
        end
        LW, LWU: begin
            va[1:0] = 2'b00;
            mask    = 8'h0f << va[2:0];
        end
        LH, LHU: begin
            va[0] = 1'b0;
            mask  = 8'h03 << va[2:0];
        end
        default: begin
            mask = 8'h01 << va[2:0];
        end
    endcase
    lsu_ctrl = '{vaddr: va, be: mask, op: op, trans_id: id};
    paddr    = paddr_t'({$random(seed), $random(seed)});
    ld_valid = 1'b1;
endtask

task automatic check_idle();
    check_value("pop_ld_o", pop_ld, 1'b0);
    check_value("translation_req_o", translation_req, 1'b0);
    check_value("data_req", dcache_req.data_req, 1'b0);
    check_value("kill_req", dcache_req.kill_req, 1'b0);
    check_value("tag_valid", dcache_req.tag_valid, 1'b0);
endtask

// called in the pop cycle and returns read data two cycles after the tag
task automatic finish_load(input data_t rdata);
    load_op_t  op;
    byte_off_t off;
    trans_id_t id;
    paddr_t    pa;
    op  = lsu_ctrl.op;
    off = lsu_ctrl.vaddr[2:0];
    id  = lsu_ctrl.trans_id;
    pa  = paddr;
    next_cycle();
    ld_valid            = 1'b0;
    dcache_rsp.data_gnt = 1'b0;
    settle();
    check_value("tag_valid", dcache_req.tag_valid, 1'b1);
    check_value("kill_req", dcache_req.kill_req, 1'b0);
    check_value("address_tag", dcache_req.address_tag, pa[PADDR_W-1:INDEX_W]);
    next_cycle();
    next_cycle();
    dcache_rsp.data_rvalid = 1'b1;
    dcache_rsp.data_rdata  = rdata;
    settle();
    check_value("valid_o", rsp_valid, 1'b1);
    check_value("trans_id_o", rsp_trans_id, id);
    check_value("result_o", rsp_result, expected_result(op, off, rdata));
    next_cycle();
    dcache_rsp.data_rvalid = 1'b0;
    settle();
    check_value("valid_o", rsp_valid, 1'b0);
endtask

// --------------------
// directed tests
// --------------------

// every op twice with grant and TLB hit in the same cycle
task automatic run_immediate_loads();
    load_op_t op;
    for (int i = 0; i < 14; i++) begin
        op = load_op_t'(i % 7);
        next_cycle();
        drive_request(op, trans_id_t'(i));
        dcache_rsp.data_gnt = 1'b1;
        dtlb_hit            = 1'b1;
        settle();
        check_value("translation_req_o", translation_req, 1'b1);
        check_value("vaddr_o", vaddr, lsu_ctrl.vaddr);
        check_value("address_index", dcache_req.address_index, lsu_ctrl.vaddr[INDEX_W-1:0]);
        check_value("data_be", dcache_req.data_be, lsu_ctrl.be);
        check_value("data_size", dcache_req.data_size, expected_size(op));
        check_value("data_req", dcache_req.data_req, 1'b1);
        check_value("pop_ld_o", pop_ld, 1'b1);
        finish_load(random_word());
    end
endtask

task automatic stall_on_grant();
    next_cycle();
    drive_request(LW, 3'd5);
    dcache_rsp.data_gnt = 1'b0;
    dtlb_hit            = 1'b1;
    // request must be held while the cache refuses it
    for (int i = 0; i < 4; i++) begin
        settle();
        check_value("data_req", dcache_req.data_req, 1'b1);
        check_value("pop_ld_o", pop_ld, 1'b0);
        next_cycle();
    end
    dcache_rsp.data_gnt = 1'b1;
    settle();
    check_value("pop_ld_o", pop_ld, 1'b1);
    finish_load(random_word());
endtask

task automatic recover_from_tlb_miss();
    next_cycle();
    drive_request(LH, 3'd2);
    dcache_rsp.data_gnt = 1'b1;
    dtlb_hit            = 1'b0;
    settle();
    check_value("data_req", dcache_req.data_req, 1'b1);
    check_value("pop_ld_o", pop_ld, 1'b0);
    next_cycle();
    dcache_rsp.data_gnt = 1'b0;
    settle();
    check_value("kill_req", dcache_req.kill_req, 1'b1);
    check_value("tag_valid", dcache_req.tag_valid, 1'b1);
    // stray read data during the page walk must not retire
    next_cycle();
    dcache_rsp.data_rvalid = 1'b1;
    dcache_rsp.data_rdata  = random_word();
    for (int i = 0; i < 3; i++) begin
        settle();
        check_value("translation_req_o", translation_req, 1'b1);
        check_value("data_req", dcache_req.data_req, 1'b0);
        check_value("valid_o", rsp_valid, 1'b0);
        next_cycle();
    end
    dtlb_hit               = 1'b1;
    dcache_rsp.data_rvalid = 1'b0;
    settle();
    check_value("translation_req_o", translation_req, 1'b1);
    check_value("data_req", dcache_req.data_req, 1'b0);
    next_cycle();
    dcache_rsp.data_gnt = 1'b1;
    settle();
    check_value("data_req", dcache_req.data_req, 1'b1);
    check_value("pop_ld_o", pop_ld, 1'b1);
    finish_load(random_word());
endtask

task automatic hold_on_page_offset();
    next_cycle();
    drive_request(LB, 3'd6);
    page_offset_match   = 1'b1;
    dcache_rsp.data_gnt = 1'b1;
    dtlb_hit            = 1'b1;
    for (int i = 0; i < 3; i++) begin
        settle();
        check_value("data_req", dcache_req.data_req, 1'b0);
        check_value("pop_ld_o", pop_ld, 1'b0);
        next_cycle();
    end
    page_offset_match = 1'b0;
    settle();
    wait_cnt = 0;
    while (!pop_ld) begin
        count_wait("pop_ld_o after the page offset match cleared");
    end
    finish_load(random_word());
endtask

task automatic retire_exception();
    next_cycle();
    drive_request(LD, 3'd7);
    ex_valid            = 1'b1;
    dcache_rsp.data_gnt = 1'b0;
    settle();
    check_value("valid_o", rsp_valid, 1'b1);
    check_value("pop_ld_o", pop_ld, 1'b1);
    check_value("trans_id_o", rsp_trans_id, 3'd7);
    check_value("data_req", dcache_req.data_req, 1'b0);
    next_cycle();
    ld_valid = 1'b0;
    ex_valid = 1'b0;
    settle();
    check_value("valid_o", rsp_valid, 1'b0);
    check_value("pop_ld_o", pop_ld, 1'b0);
endtask

// flush while the request still waits for its grant
task automatic flush_open_request();
    next_cycle();
    drive_request(LHU, 3'd1);
    dcache_rsp.data_gnt = 1'b0;
    settle();
    check_value("data_req", dcache_req.data_req, 1'b1);
    next_cycle();
    flush = 1'b1;
    next_cycle();
    flush                  = 1'b0;
    ld_valid               = 1'b0;
    dcache_rsp.data_rvalid = 1'b1;
    dcache_rsp.data_rdata  = random_word();
    settle();
    check_value("kill_req", dcache_req.kill_req, 1'b1);
    check_value("tag_valid", dcache_req.tag_valid, 1'b1);
    check_value("valid_o", rsp_valid, 1'b0);
    next_cycle();
    dcache_rsp.data_rvalid = 1'b0;
    settle();
    check_idle();
endtask

/* testbench/tb_load_unit.sv */
`timescale 1ns/1ns

module tb_load_unit;

    import load_pkg::*;

    logic        clk_i;
    logic        rst_ni;
    logic        flush;
    logic        ld_valid;
    load_ctrl_t  lsu_ctrl;
    logic        ex_valid;
    logic        pop_ld;
    logic        rsp_valid;
    trans_id_t   rsp_trans_id;
    data_t       rsp_result;
    logic        translation_req;
    vaddr_t      vaddr;
    paddr_t      paddr;
    logic        dtlb_hit;
    logic        page_offset_match;
    dcache_req_t dcache_req;
    dcache_rsp_t dcache_rsp;

    // fixed seed so every run sees the same data and addresses
    integer      seed        = 87;
    int          wait_cnt    = 0;
    int unsigned wait_limit  = 50;

    load_unit i_dut (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush),
        .valid_i             (ld_valid),
        .lsu_ctrl_i          (lsu_ctrl),
        .ex_valid_i          (ex_valid),
        .pop_ld_o            (pop_ld),
        .valid_o             (rsp_valid),
        .trans_id_o          (rsp_trans_id),
        .result_o            (rsp_result),
        .translation_req_o   (translation_req),
        .vaddr_o             (vaddr),
        .paddr_i             (paddr),
        .dtlb_hit_i          (dtlb_hit),
        .page_offset_match_i (page_offset_match),
        .dcache_req_o        (dcache_req),
        .dcache_rsp_i        (dcache_rsp)
    );

    // 10 ns clock
    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------
    // error reporting
    // --------------------

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAIL time %0t: %s is %0h, expected %0h", $time, sig, got, exp);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("FAIL time %0t: timed out waiting for %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    `include "load_tb_tasks.svh"

    initial begin
        rst_ni            = 1'b0;
        flush             = 1'b0;
        ld_valid          = 1'b0;
        lsu_ctrl          = '0;
        ex_valid          = 1'b0;
        paddr             = '0;
        dtlb_hit          = 1'b0;
        page_offset_match = 1'b0;
        dcache_rsp        = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        settle();
        check_idle();
        run_immediate_loads();
        stall_on_grant();
        recover_from_tlb_miss();
        hold_on_page_offset();
        retire_exception();
        flush_open_request();
        next_cycle();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
hdl/load_pkg.sv
hdl/load_req_ctrl.sv
hdl/load_info_reg.sv
hdl/load_result_align.sv
hdl/load_unit.sv
testbench/tb_load_unit.sv
